// File: build.f
logic/if_pkg.sv
logic/fetch_bus_if.sv
logic/instr_stream_if.sv
logic/if_pc_mux.sv
logic/if_prefetch_unit.sv
logic/if_obi_master.sv
logic/if_aligner.sv
logic/if_id_pipe.sv
logic/if_stage_top.sv
tb/tb_if_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_if_stage -f build.f \
  --Mdir obj_dir -o tb_if_stage

./obj_dir/tb_if_stage | tee sim.log

# The log decides the result
if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tb/tb_if_stage.sv
`timescale 1ns/1ps

module tb_if_stage;

  localparam int unsigned FETCH_DEPTH = if_pkg::DEF_FETCH_DEPTH;
  localparam int unsigned CLK_PERIOD  = 40;

  // Instructions collected by each test
  localparam int unsigned N_BOOT  = 12;
  localparam int unsigned N_MIX   = 32;
  localparam int unsigned N_REDIR = 16;
  localparam int unsigned N_TRAP  = 12;
  localparam int unsigned N_BP    = 40;
  localparam int unsigned N_ERR   = 5;
  localparam int unsigned TIMEOUT_CYCLES =
    (N_BOOT + N_MIX + N_REDIR + N_TRAP + N_BP + N_ERR) * 20 + 10;

  // A single word answers with err set
  localparam logic [31:0] ERR_LO = 32'h0000_0800;
  localparam logic [31:0] ERR_HI = 32'h0000_0803;

  typedef struct {
    logic [if_pkg::XLEN-1:0] instr;
    logic [if_pkg::XLEN-1:0] pc;
    logic                    c;
    logic                    err;
  } cap_t;

  typedef struct {
    logic [if_pkg::XLEN-1:0] addr;
    int                      due;
  } resp_t;

  logic                        clk;
  logic                        rst_n;
  logic                        pc_set_i;
  if_pkg::pc_sel_e             pc_sel_i;
  logic                        halt_if_i;
  logic [if_pkg::XLEN-1:0]     boot_addr_i;
  logic [if_pkg::XLEN-1:0]     jump_target_i;
  logic [if_pkg::XLEN-1:0]     branch_target_i;
  logic [if_pkg::XLEN-1:0]     mepc_i;
  logic [if_pkg::MTVEC_W-1:0]  mtvec_addr_i;
  logic [if_pkg::IRQ_ID_W-1:0] irq_id_i;
  logic                        csr_mtvec_init_o;
  logic                        if_busy_o;
  logic                        instr_req_o;
  logic [if_pkg::XLEN-1:0]     instr_addr_o;
  logic                        instr_gnt_i;
  logic                        instr_rvalid_i;
  logic [if_pkg::XLEN-1:0]     instr_rdata_i;
  logic                        instr_err_i;
  logic                        id_valid_o;
  logic [if_pkg::XLEN-1:0]     id_instr_o;
  logic [if_pkg::XLEN-1:0]     id_pc_o;
  logic                        id_compressed_o;
  logic                        id_bus_err_o;
  logic                        id_ready_i;

  cap_t  cap_q[$];
  cap_t  mon_cap;
  resp_t resp_q[$];
  resp_t resp_entry;
  int    cyc = 0;
  int    gnt_wait = 0;
  int    err_cnt = 0;
  int    test_err_start = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    straddles;
  string cur_test = "reset";

  if_stage_top #(
    .FETCH_DEPTH (FETCH_DEPTH)
  ) dut_i (
    .clk (clk), .rst_n (rst_n),
    .pc_set_i (pc_set_i), .pc_sel_i (pc_sel_i), .halt_if_i (halt_if_i),
    .boot_addr_i (boot_addr_i), .jump_target_i (jump_target_i),
    .branch_target_i (branch_target_i), .mepc_i (mepc_i),
    .mtvec_addr_i (mtvec_addr_i), .irq_id_i (irq_id_i),
    .csr_mtvec_init_o (csr_mtvec_init_o), .if_busy_o (if_busy_o),
    .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .instr_gnt_i (instr_gnt_i), .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i), .instr_err_i (instr_err_i),
    .id_valid_o (id_valid_o), .id_instr_o (id_instr_o), .id_pc_o (id_pc_o),
    .id_compressed_o (id_compressed_o), .id_bus_err_o (id_bus_err_o),
    .id_ready_i (id_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // Memory content and bus model
  ////////////////////////////////////////////////////////////////////////

  // Where address bit 12 is low every word is one aligned 32-bit instruction
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] h;
    h = addr * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    if (!addr[12]) begin
      h[1:0] = 2'b11;
    end
    return h;
  endfunction

  function automatic logic [15:0] mem_half(input logic [31:0] addr);
    logic [31:0] w;
    w = mem_word({addr[31:2], 2'b00});
    return addr[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr <= ERR_HI);
  endfunction

  // Grants and responses change on the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      instr_gnt_i    = 1'b0;
      instr_rvalid_i = 1'b0;
      resp_q.delete();
    end else begin
      cyc = cyc + 1;
      // Oldest granted request answers first
      if (resp_q.size() != 0 && resp_q[0].due <= cyc) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = mem_word(resp_q[0].addr);
        instr_err_i    = in_err_window(resp_q[0].addr);
        void'(resp_q.pop_front());
      end else begin
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        instr_err_i    = 1'b0;
      end
      // Request is registered, so it still stands at the next rising edge
      instr_gnt_i = 1'b0;
      if (instr_req_o) begin
        if (gnt_wait == 0) begin
          instr_gnt_i      = 1'b1;
          resp_entry.addr  = instr_addr_o;
          resp_entry.due   = cyc + 1 + int'($urandom % 4);
          resp_q.push_back(resp_entry);
          gnt_wait = int'($urandom % 4);
        end else begin
          gnt_wait = gnt_wait - 1;
        end
      end
      if (resp_q.size() > FETCH_DEPTH) begin
        $display("error: %s has more than %0d bus requests outstanding",
                 cur_test, FETCH_DEPTH);
        err_cnt++;
      end
    end
  end

  // Capture decode side transfers and drop them on a redirect edge
  always @(posedge clk) begin
    if (pc_set_i) begin
      cap_q.delete();
    end else if (rst_n && id_valid_o && id_ready_i) begin
      mon_cap.instr = id_instr_o;
      mon_cap.pc    = id_pc_o;
      mon_cap.c     = id_compressed_o;
      mon_cap.err   = id_bus_err_o;
      cap_q.push_back(mon_cap);
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////
  // Compare tasks and helpers
  ////////////////////////////////////////////////////////////////////////

  task automatic check_addr(input string name, input logic [if_pkg::XLEN-1:0] exp,
                            input logic [if_pkg::XLEN-1:0] act);
    if (act !== exp) begin
      $display("error: %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error: %s expected %b actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  // Only a boot redirect asks the CSR file to load mtvec
  task automatic check_pc_sel_init(input string name, input if_pkg::pc_sel_e sel,
                                   input logic act);
    check_flag({name, " mtvec init"}, sel == if_pkg::PC_BOOT, act);
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt == test_err_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, err_cnt - test_err_start);
    end
  endtask

  // One-cycle redirect with the unused sources on other addresses
  task automatic redirect(input if_pkg::pc_sel_e sel, input logic [31:0] target);
    @(negedge clk);
    pc_sel_i        = sel;
    boot_addr_i     = 32'h0000_3000;
    jump_target_i   = 32'h0000_3100;
    branch_target_i = 32'h0000_3200;
    mepc_i          = 32'h0000_3300;
    case (sel)
      if_pkg::PC_BOOT:   boot_addr_i     = target;
      if_pkg::PC_JUMP:   jump_target_i   = target;
      if_pkg::PC_BRANCH: branch_target_i = target;
      if_pkg::PC_MRET:   mepc_i          = target;
      default:           ;
    endcase
    pc_set_i = 1'b1;
    @(posedge clk);
    check_pc_sel_init(cur_test, sel, csr_mtvec_init_o);
    @(negedge clk);
    pc_set_i = 1'b0;
    @(posedge clk);
    check_flag({cur_test, " mtvec init after pulse"}, 1'b0, csr_mtvec_init_o);
  endtask

  task automatic wait_instr(input int n);
    while (cap_q.size() < n) begin
      @(negedge clk);
    end
  endtask

  // Walk memory by the halfword rule and compare with the captured stream
  task automatic compare_stream(input logic [31:0] start, input int n, output int nstr);
    logic [31:0] pc;
    logic [15:0] hw;
    logic        c;
    logic [31:0] instr;
    logic        err;
    nstr = 0;
    pc   = {start[31:1], 1'b0};
    for (int i = 0; i < n; i++) begin
      hw    = mem_half(pc);
      c     = hw[1:0] != 2'b11;
      instr = c ? {16'h0000, hw} : {mem_half(pc + 2), hw};
      err   = in_err_window(pc) || (!c && in_err_window(pc + 2));
      if (!c && pc[1]) begin
        nstr++;
      end
      check_addr($sformatf("%s pc[%0d]", cur_test, i), pc, cap_q[i].pc);
      check_addr($sformatf("%s instr[%0d]", cur_test, i), instr, cap_q[i].instr);
      check_flag($sformatf("%s compressed[%0d]", cur_test, i), c, cap_q[i].c);
      check_flag($sformatf("%s bus_err[%0d]", cur_test, i), err, cap_q[i].err);
      pc = pc + (c ? 2 : 4);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////

  task automatic boot_sequence();
    begin_test("boot");
    // Quiet until the first redirect
    check_flag("boot id_valid after reset", 1'b0, id_valid_o);
    check_flag("boot instr_req after reset", 1'b0, instr_req_o);
    check_flag("boot mtvec init after reset", 1'b0, csr_mtvec_init_o);
    check_flag("boot busy after reset", 1'b0, if_busy_o);
    redirect(if_pkg::PC_BOOT, 32'h0000_0102);
    @(negedge clk);
    check_flag("boot busy while fetching", 1'b1, if_busy_o);
    wait_instr(N_BOOT);
    compare_stream(32'h0000_0100, N_BOOT, straddles);
    end_test();
  endtask

  task automatic compressed_mix();
    begin_test("compressed_mix");
    redirect(if_pkg::PC_BRANCH, 32'h0000_1000);
    wait_instr(N_MIX);
    compare_stream(32'h0000_1000, N_MIX, straddles);
    if (straddles == 0) begin
      $display("error: %s saw no 32-bit instruction across a word boundary", cur_test);
      err_cnt++;
    end
    end_test();
  endtask

  task automatic jump_branch_redirect();
    begin_test("redirect");
    redirect(if_pkg::PC_BOOT, 32'h0000_0300);
    wait_instr(2);
    // Jump lands while words are still in flight and loses bit 0
    redirect(if_pkg::PC_JUMP, 32'h0000_1237);
    wait_instr(6);
    compare_stream(32'h0000_1236, 6, straddles);
    redirect(if_pkg::PC_BRANCH, 32'h0000_0402);
    wait_instr(6);
    compare_stream(32'h0000_0402, 6, straddles);
    // Return from a trap goes back to mepc
    redirect(if_pkg::PC_MRET, 32'h0000_0500);
    wait_instr(2);
    compare_stream(32'h0000_0500, 2, straddles);
    end_test();
  endtask

  task automatic trap_vectors();
    begin_test("traps");
    @(negedge clk);
    mtvec_addr_i = 25'h000_0040;
    irq_id_i     = 5'd3;
    // Base 0x40 shifted by seven lands at 0x2000
    redirect(if_pkg::PC_TRAP_EXC, 32'h0);
    wait_instr(6);
    compare_stream(32'h0000_2000, 6, straddles);
    // Interrupt 3 sits three words above the base
    redirect(if_pkg::PC_TRAP_IRQ, 32'h0);
    wait_instr(6);
    compare_stream(32'h0000_200c, 6, straddles);
    end_test();
  endtask

  task automatic backpressure_halt();
    begin_test("backpressure");
    redirect(if_pkg::PC_JUMP, 32'h0000_1100);
    while (cap_q.size() < N_BP) begin
      @(negedge clk);
      id_ready_i = ($urandom % 3) != 0;
      halt_if_i  = ($urandom % 4) == 0;
    end
    @(negedge clk);
    id_ready_i = 1'b1;
    halt_if_i  = 1'b0;
    compare_stream(32'h0000_1100, N_BP, straddles);
    end_test();
  endtask

  task automatic bus_error_window();
    begin_test("bus_error");
    redirect(if_pkg::PC_JUMP, 32'h0000_07f8);
    wait_instr(N_ERR);
    compare_stream(32'h0000_07f8, N_ERR, straddles);
    end_test();
  endtask

  initial begin
    void'($urandom(32'hdf92));
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_sel_i        = if_pkg::PC_BOOT;
    halt_if_i       = 1'b0;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_err_i     = 1'b0;
    id_ready_i      = 1'b1;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(posedge clk);

    boot_sequence();
    compressed_mix();
    jump_branch_redirect();
    trap_vectors();
    backpressure_halt();
    bus_error_window();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: logic/if_stage_top.sv
`timescale 1ns/1ps

module if_stage_top #(
  parameter int unsigned FETCH_DEPTH = if_pkg::DEF_FETCH_DEPTH
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // Redirect control and targets
  input  logic                        pc_set_i,
  input  if_pkg::pc_sel_e             pc_sel_i,
  input  logic                        halt_if_i,
  input  logic [if_pkg::XLEN-1:0]     boot_addr_i,
  input  logic [if_pkg::XLEN-1:0]     jump_target_i,
  input  logic [if_pkg::XLEN-1:0]     branch_target_i,
  input  logic [if_pkg::XLEN-1:0]     mepc_i,
  input  logic [if_pkg::MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [if_pkg::IRQ_ID_W-1:0] irq_id_i,
  output logic                        csr_mtvec_init_o,
  output logic                        if_busy_o,
  // Instruction bus
  output logic                        instr_req_o,
  output logic [if_pkg::XLEN-1:0]     instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [if_pkg::XLEN-1:0]     instr_rdata_i,
  input  logic                        instr_err_i,
  // Decode side
  output logic                        id_valid_o,
  output logic [if_pkg::XLEN-1:0]     id_instr_o,
  output logic [if_pkg::XLEN-1:0]     id_pc_o,
  output logic                        id_compressed_o,
  output logic                        id_bus_err_o,
  input  logic                        id_ready_i
);

  logic [if_pkg::XLEN-1:0] fetch_addr;
  logic                    word_valid;
  if_pkg::fetch_word_t     word;
  logic [if_pkg::XLEN-1:0] word_addr;
  logic                    word_pop;

  fetch_bus_if    fetch_bus ();
  instr_stream_if instr_stream ();

  //////////////////////////////////////////////////////////////////////
  // Next fetch address
  //////////////////////////////////////////////////////////////////////

  if_pc_mux pc_mux_i (
    .pc_set_i         (pc_set_i),
    .pc_sel_i         (pc_sel_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .fetch_addr_o     (fetch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Prefetch and bus
  //////////////////////////////////////////////////////////////////////

  if_prefetch_unit #(
    .FETCH_DEPTH (FETCH_DEPTH)
  ) prefetch_unit_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (fetch_addr),
    .pop_i         (word_pop),
    .word_valid_o  (word_valid),
    .word_o        (word),
    .word_addr_o   (word_addr),
    .busy_o        (if_busy_o),
    .bus           (fetch_bus.prefetch)
  );

  if_obi_master obi_master_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .bus            (fetch_bus.adapter)
  );

  //////////////////////////////////////////////////////////////////////
  // Instruction split and IF/ID register
  //////////////////////////////////////////////////////////////////////

  if_aligner aligner_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (fetch_addr),
    .word_valid_i  (word_valid),
    .word_i        (word),
    .word_addr_i   (word_addr),
    .pop_o         (word_pop),
    .out           (instr_stream.source)
  );

  if_id_pipe id_pipe_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set_i),
    .halt_if_i       (halt_if_i),
    .id_ready_i      (id_ready_i),
    .id_valid_o      (id_valid_o),
    .id_instr_o      (id_instr_o),
    .id_pc_o         (id_pc_o),
    .id_compressed_o (id_compressed_o),
    .id_bus_err_o    (id_bus_err_o),
    .in              (instr_stream.sink)
  );

endmodule

// File: logic/if_id_pipe.sv
`timescale 1ns/1ps

module if_id_pipe (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pc_set_i,
  input  logic                     halt_if_i,
  input  logic                     id_ready_i,
  output logic                     id_valid_o,
  output logic [if_pkg::XLEN-1:0]  id_instr_o,
  output logic [if_pkg::XLEN-1:0]  id_pc_o,
  output logic                     id_compressed_o,
  output logic                     id_bus_err_o,
  instr_stream_if.sink             in
);

  logic                    valid_q;
  logic [if_pkg::XLEN-1:0] instr_q;
  logic [if_pkg::XLEN-1:0] pc_q;
  logic                    comp_q;
  logic                    err_q;
  logic                    xfer;

  // Empty or drained by decode, not halted, no redirect this cycle
  assign in.ready = (!valid_q || id_ready_i) && !halt_if_i && !pc_set_i;
  assign xfer     = in.valid && in.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (pc_set_i) begin
      valid_q <= 1'b0;
    end else if (xfer) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      // Decode took the entry and nothing replaced it
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      // Raw halfword goes to decode, upper bits zero
      instr_q <= in.compressed ? {{(if_pkg::XLEN - 16){1'b0}}, in.instr[15:0]} : in.instr;
      pc_q    <= in.pc;
      comp_q  <= in.compressed;
      err_q   <= in.err;
    end
  end

  assign id_valid_o      = valid_q;
  assign id_instr_o      = instr_q;
  assign id_pc_o         = pc_q;
  assign id_compressed_o = comp_q;
  assign id_bus_err_o    = err_q;

endmodule

// File: logic/if_aligner.sv
`timescale 1ns/1ps

module if_aligner (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pc_set_i,
  input  logic [if_pkg::XLEN-1:0]  branch_addr_i,
  input  logic                     word_valid_i,
  input  if_pkg::fetch_word_t      word_i,
  input  logic [if_pkg::XLEN-1:0]  word_addr_i,
  output logic                     pop_o,
  instr_stream_if.source           out
);

  logic                    half_q;
  logic                    resid_valid_q;
  logic [15:0]             resid_q;
  logic                    resid_err_q;
  logic [if_pkg::XLEN-1:0] resid_pc_q;
  logic [15:0]             hw_lo;
  logic [15:0]             hw_hi;
  logic [15:0]             cur_hw;
  logic                    cur_c;
  logic                    split;
  logic                    take;

  assign hw_lo  = word_i.data[15:0];
  assign hw_hi  = word_i.data[31:16];
  assign cur_hw = half_q ? hw_hi : hw_lo;

  // Low bits other than 2'b11 mark a 16-bit instruction
  assign cur_c = cur_hw[1:0] != 2'b11;

  // 32-bit instruction in the upper half continues in the next word
  assign split = !resid_valid_q && half_q && !cur_c;

  always_comb begin
    out.valid      = word_valid_i && !split;
    out.compressed = !resid_valid_q && cur_c;
    out.err        = word_i.err || (resid_valid_q && resid_err_q);
    out.pc         = {word_addr_i[if_pkg::XLEN-1:2], half_q, 1'b0};
    if (resid_valid_q) begin
      // Lower half of the new word completes the saved upper half
      out.instr = {hw_lo, resid_q};
      out.pc    = resid_pc_q;
    end else if (half_q) begin
      out.instr = {16'h0000, hw_hi};
    end else begin
      out.instr = word_i.data;
    end
  end

  assign take = out.valid && out.ready;

  // Word leaves once nothing else in it is needed
  assign pop_o = word_valid_i &&
                 (split || (take && !resid_valid_q && (half_q || !cur_c)));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q        <= 1'b0;
      resid_valid_q <= 1'b0;
    end else if (pc_set_i) begin
      // Start at the halfword named by the target
      half_q        <= branch_addr_i[1];
      resid_valid_q <= 1'b0;
    end else if (split && word_valid_i) begin
      resid_valid_q <= 1'b1;
    end else if (take) begin
      resid_valid_q <= 1'b0;
      // Only 16-bit steps move to the other half
      if (out.compressed) begin
        half_q <= ~half_q;
      end
    end
  end

  // Upper half waiting for its partner
  always_ff @(posedge clk) begin
    if (split && word_valid_i) begin
      resid_q     <= hw_hi;
      resid_err_q <= word_i.err;
      resid_pc_q  <= {word_addr_i[if_pkg::XLEN-1:2], 2'b10};
    end
  end

endmodule

// File: logic/if_obi_master.sv
`timescale 1ns/1ps

module if_obi_master (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  input  logic [if_pkg::XLEN-1:0]  instr_rdata_i,
  input  logic                     instr_err_i,
  output logic                     instr_req_o,
  output logic [if_pkg::XLEN-1:0]  instr_addr_o,
  fetch_bus_if.adapter             bus
);

  logic                    req_q;
  logic [if_pkg::XLEN-1:0] addr_q;
  logic                    accept;

  // Free slot, or the held request leaves this cycle
  assign accept  = !req_q || instr_gnt_i;
  assign bus.gnt = accept;

  // Request stays on the pins until granted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
    end else if (bus.req && accept) begin
      req_q <= 1'b1;
    end else if (instr_gnt_i) begin
      req_q <= 1'b0;
    end
  end

  // Address is frozen while the request waits
  always_ff @(posedge clk) begin
    if (bus.req && accept) begin
      addr_q <= bus.addr;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = addr_q;

  // Responses come back in order, passed through as they arrive
  assign bus.rvalid = instr_rvalid_i;
  assign bus.rdata  = instr_rdata_i;
  assign bus.err    = instr_err_i;

endmodule

// File: logic/if_prefetch_unit.sv
`timescale 1ns/1ps

module if_prefetch_unit #(
  parameter int unsigned FETCH_DEPTH = if_pkg::DEF_FETCH_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     pc_set_i,
  input  logic [if_pkg::XLEN-1:0]  branch_addr_i,
  input  logic                     pop_i,
  output logic                     word_valid_o,
  output if_pkg::fetch_word_t      word_o,
  output logic [if_pkg::XLEN-1:0]  word_addr_o,
  output logic                     busy_o,
  fetch_bus_if.prefetch            bus
);

  localparam int unsigned CNT_W = $clog2(FETCH_DEPTH + 1);
  localparam int unsigned PTR_W = $clog2(FETCH_DEPTH);

  logic [if_pkg::XLEN-1:0] target_word;
  logic [if_pkg::XLEN-1:0] fetch_addr_q;
  logic [if_pkg::XLEN-1:0] resp_addr_q;
  logic                    active_q;
  logic [CNT_W-1:0]        outst_q;
  logic [CNT_W-1:0]        discard_q;
  logic [CNT_W-1:0]        fifo_cnt_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [CNT_W:0]          occupancy;
  logic                    room;
  logic                    issue;
  logic                    keep;
  logic                    do_pop;

  if_pkg::fetch_word_t     word_mem [FETCH_DEPTH];
  logic [if_pkg::XLEN-1:0] addr_mem [FETCH_DEPTH];

  // Wrap at the buffer depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FETCH_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign target_word = {branch_addr_i[if_pkg::XLEN-1:2], 2'b00};

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Buffered words plus requests in flight never exceed the depth
  assign occupancy = {1'b0, fifo_cnt_q} + {1'b0, outst_q};
  assign room      = occupancy < (CNT_W + 1)'(FETCH_DEPTH);

  // Old address is stale during a redirect cycle
  assign bus.req  = active_q && room && !pc_set_i;
  assign bus.addr = fetch_addr_q;
  assign issue    = bus.req && bus.gnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
      resp_addr_q  <= '0;
    end else if (pc_set_i) begin
      // Fetching starts with the first redirect
      active_q     <= 1'b1;
      fetch_addr_q <= target_word;
      resp_addr_q  <= target_word;
    end else begin
      if (issue) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      if (keep) begin
        resp_addr_q <= resp_addr_q + 32'd4;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////////////////////////

  // Responses owed to requests from before a redirect are dropped
  assign keep   = bus.rvalid && (discard_q == '0) && !pc_set_i;
  assign do_pop = pop_i && word_valid_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q   <= '0;
      discard_q <= '0;
    end else begin
      outst_q <= outst_q + CNT_W'(issue) - CNT_W'(bus.rvalid);
      if (pc_set_i) begin
        // Everything still in flight is stale
        discard_q <= outst_q - CNT_W'(bus.rvalid);
      end else if (bus.rvalid && (discard_q != '0)) begin
        discard_q <= discard_q - 1'b1;
      end
    end
  end

  // Buffer control, flushed on the redirect edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_cnt_q <= '0;
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
    end else if (pc_set_i) begin
      fifo_cnt_q <= '0;
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
    end else begin
      fifo_cnt_q <= fifo_cnt_q + CNT_W'(keep) - CNT_W'(do_pop);
      if (keep) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  // Buffer storage
  always_ff @(posedge clk) begin
    if (keep) begin
      word_mem[wr_ptr_q] <= '{err: bus.err, data: bus.rdata};
      addr_mem[wr_ptr_q] <= resp_addr_q;
    end
  end

  // Head of the buffer
  assign word_valid_o = fifo_cnt_q != '0;
  assign word_o       = word_mem[rd_ptr_q];
  assign word_addr_o  = addr_mem[rd_ptr_q];

  assign busy_o = (outst_q != '0) || bus.req;

endmodule

// File: logic/if_pc_mux.sv
`timescale 1ns/1ps

module if_pc_mux (
  input  logic                        pc_set_i,
  input  if_pkg::pc_sel_e             pc_sel_i,
  input  logic [if_pkg::XLEN-1:0]     boot_addr_i,
  input  logic [if_pkg::XLEN-1:0]     jump_target_i,
  input  logic [if_pkg::XLEN-1:0]     branch_target_i,
  input  logic [if_pkg::XLEN-1:0]     mepc_i,
  input  logic [if_pkg::MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [if_pkg::IRQ_ID_W-1:0] irq_id_i,
  output logic [if_pkg::XLEN-1:0]     fetch_addr_o,
  output logic                        csr_mtvec_init_o
);

  logic [if_pkg::XLEN-1:0] target;

  always_comb begin
    // Boot target is word aligned
    target = {boot_addr_i[if_pkg::XLEN-1:2], 2'b00};
    unique case (pc_sel_i)
      if_pkg::PC_BOOT:     target = {boot_addr_i[if_pkg::XLEN-1:2], 2'b00};
      if_pkg::PC_JUMP:     target = jump_target_i;
      if_pkg::PC_BRANCH:   target = branch_target_i;
      // Return to the interrupted instruction
      if_pkg::PC_MRET:     target = mepc_i;
      // All exceptions share the vector base
      if_pkg::PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};
      // Interrupts are vectored by their index
      if_pkg::PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      default:             target = {boot_addr_i[if_pkg::XLEN-1:2], 2'b00};
    endcase
  end

  // Halfword aligned, bit 0 never fetched
  assign fetch_addr_o = {target[if_pkg::XLEN-1:1], 1'b0};

  // CSR file loads mtvec from the boot address
  assign csr_mtvec_init_o = pc_set_i && (pc_sel_i == if_pkg::PC_BOOT);

endmodule

// File: logic/instr_stream_if.sv
`timescale 1ns/1ps

interface instr_stream_if;

  // Offered instruction, held until taken
  logic                     valid;
  logic [if_pkg::XLEN-1:0]  instr;
  logic [if_pkg::XLEN-1:0]  pc;
  logic                     compressed;
  logic                     err;

  // Sink side acceptance
  logic                     ready;

  modport source (
    output valid, instr, pc, compressed, err,
    input  ready
  );

  modport sink (
    input  valid, instr, pc, compressed, err,
    output ready
  );

endinterface

// File: logic/fetch_bus_if.sv
`timescale 1ns/1ps

interface fetch_bus_if;

  // Request channel
  logic                     req;
  logic [if_pkg::XLEN-1:0]  addr;
  logic                     gnt;

  // Response channel, in order, one per granted request
  logic                     rvalid;
  logic [if_pkg::XLEN-1:0]  rdata;
  logic                     err;

  modport prefetch (
    output req, addr,
    input  gnt, rvalid, rdata, err
  );

  modport adapter (
    input  req, addr,
    output gnt, rvalid, rdata, err
  );

endinterface

// File: logic/if_pkg.sv
package if_pkg;

  // Address and instruction word width
  parameter int unsigned XLEN = 32;

  // Upper bits of the trap vector base held in mtvec
  parameter int unsigned MTVEC_W = 25;

  // Interrupt index used to build the vectored target
  parameter int unsigned IRQ_ID_W = 5;

  // Outstanding fetches and prefetch buffer entries
  parameter int unsigned DEF_FETCH_DEPTH = 3;

  // Redirect source of the fetch address
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_sel_e;

  // One instruction bus response
  // Error bit on top, data word below
  typedef struct packed {
    logic            err;
    logic [XLEN-1:0] data;
  } fetch_word_t;

endpackage
